// ==== source/icache_cfg.svh ====
`ifndef ICACHE_CFG_SVH
`define ICACHE_CFG_SVH

// word address seen by the fetch path
`define ICACHE_ADDR_W 16

// direct mapped, one word per line
`define ICACHE_INDEX_W 4

// upper address bits kept per line
`define ICACHE_TAG_W 12

// instruction word
`define ICACHE_DATA_W 32

// entries in each of the request and response queues
`define ICACHE_QUEUE_DEPTH 4

`endif

// ==== source/icache_pkg.sv ====
`include "icache_cfg.svh"

package icache_pkg;

    typedef struct packed {
        logic [`ICACHE_ADDR_W-1:0] addr;
    } fetch_req_t;

    typedef struct packed {
        logic [`ICACHE_ADDR_W-1:0] addr;
        logic [`ICACHE_DATA_W-1:0] data;
    } fetch_resp_t;

    // one cache line
    typedef struct packed {
        logic                      valid;
        logic [`ICACHE_TAG_W-1:0]  tag;
        logic [`ICACHE_DATA_W-1:0] data;
    } line_entry_t;

    // master to slave
    typedef struct packed {
        logic                      cyc;
        logic                      stb;
        logic [`ICACHE_ADDR_W-1:0] adr;
    } wb_req_t;

    // slave to master
    typedef struct packed {
        logic                      ack;
        logic [`ICACHE_DATA_W-1:0] dat;
    } wb_resp_t;

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        FILL,
        RESPOND
    } ctrl_state_t;

endpackage

// ==== source/fetch_queue.sv ====
module fetch_queue #(
    parameter type payload_t = logic [7:0],
    parameter int  depth     = 4
) (
    input  logic     clk,
    input  logic     rst,

    input  payload_t in_data,
    input  logic     in_valid,
    output logic     in_ready,

    output payload_t out_data,
    output logic     out_valid,
    input  logic     out_ready
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    payload_t         mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             push;
    logic             pop;

    // wrap explicitly so depth need not be a power of two
    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        logic [ptr_w-1:0] result;
        if (ptr == ptr_w'(depth - 1))
            result = '0;
        else
            result = ptr + 1'b1;
        return result;
    endfunction

    assign in_ready  = (count != cnt_w'(depth));
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= next_ptr(wr_ptr);
            if (pop)
                rd_ptr <= next_ptr(rd_ptr);

            // simultaneous push and pop leaves occupancy unchanged
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= in_data;
    end

endmodule

// ==== source/wb_line_fill.sv ====
`include "icache_cfg.svh"

module wb_line_fill
    import icache_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,

    input  logic                      fill_start,
    input  logic [`ICACHE_ADDR_W-1:0] fill_addr,
    output logic                      fill_done,
    output logic [`ICACHE_DATA_W-1:0] fill_data,

    output wb_req_t                   wb_out,
    input  wb_resp_t                  wb_in
);

    // two states: idle when low, bus cycle open when high
    logic                      busy;
    logic [`ICACHE_ADDR_W-1:0] adr_q;

    // cyc and stb come straight from the state bit
    assign wb_out.cyc = busy;
    assign wb_out.stb = busy;
    assign wb_out.adr = adr_q;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy      <= 1'b0;
            fill_done <= 1'b0;
        end
        else
        begin
            fill_done <= 1'b0;
            if (!busy)
            begin
                if (fill_start)
                    busy <= 1'b1;
            end
            else if (wb_in.ack)
            begin
                // close the cycle, report one cycle later
                busy      <= 1'b0;
                fill_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (!busy && fill_start)
            adr_q <= fill_addr;
        if (busy && wb_in.ack)
            fill_data <= wb_in.dat;
    end

endmodule

// ==== source/icache_ctrl.sv ====
`include "icache_cfg.svh"

module icache_ctrl
    import icache_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      flush,

    // from request queue
    input  fetch_req_t                req,
    input  logic                      req_valid,
    output logic                      req_ready,

    // to response queue
    output fetch_resp_t               resp,
    output logic                      resp_valid,
    input  logic                      resp_ready,

    // fill master
    output logic                      fill_start,
    output logic [`ICACHE_ADDR_W-1:0] fill_addr,
    input  logic                      fill_done,
    input  logic [`ICACHE_DATA_W-1:0] fill_data
);

    localparam int num_lines = 1 << `ICACHE_INDEX_W;

    line_entry_t                lines [num_lines];
    line_entry_t                line_q;
    fetch_resp_t                resp_q;
    ctrl_state_t                state;
    ctrl_state_t                state_next;
    logic [`ICACHE_INDEX_W-1:0] req_index;
    logic [`ICACHE_TAG_W-1:0]   req_tag;
    logic                       pop;
    logic                       hit;
    logic                       fill_write;

    // address of the request in flight
    assign req_index = resp_q.addr[`ICACHE_INDEX_W-1:0];
    assign req_tag   = resp_q.addr[`ICACHE_ADDR_W-1:`ICACHE_INDEX_W];

    // flush has priority over a waiting request
    assign req_ready = (state == IDLE) && !flush;
    assign pop       = req_ready && req_valid;

    assign hit        = line_q.valid && (line_q.tag == req_tag);
    assign fill_write = (state == FILL) && fill_done;

    assign fill_start = (state == LOOKUP) && !hit;
    assign fill_addr  = resp_q.addr;

    assign resp       = resp_q;
    assign resp_valid = (state == RESPOND);

    always_comb
    begin
        state_next = state;
        case (state)
            IDLE:
            begin
                if (pop)
                    state_next = LOOKUP;
            end
            LOOKUP:
            begin
                if (hit)
                    state_next = RESPOND;
                else
                    state_next = FILL;
            end
            FILL:
            begin
                if (fill_done)
                    state_next = RESPOND;
            end
            RESPOND:
            begin
                // stays here while the response queue is full
                if (resp_ready)
                    state_next = IDLE;
            end
            default:
                state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= IDLE;
        else
            state <= state_next;
    end

    // valid bits cleared by reset and by flush, tag and data only on fill
    always_ff @(posedge clk)
    begin
        if (rst || (state == IDLE && flush))
        begin
            for (int i = 0; i < num_lines; i++)
                lines[i].valid <= 1'b0;
        end
        else if (fill_write)
        begin
            lines[req_index] <= '{valid: 1'b1, tag: req_tag, data: fill_data};
        end
    end

    always_ff @(posedge clk)
    begin
        if (pop)
        begin
            resp_q.addr <= req.addr;
            // registered array read for the LOOKUP cycle
            line_q      <= lines[req.addr[`ICACHE_INDEX_W-1:0]];
        end

        if (state == LOOKUP && hit)
            resp_q.data <= line_q.data;
        else if (fill_write)
            resp_q.data <= fill_data;
    end

endmodule

// ==== source/icache_top.sv ====
`include "icache_cfg.svh"

module icache_top
    import icache_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        flush,

    input  fetch_req_t  req,
    input  logic        req_valid,
    output logic        req_ready,

    output fetch_resp_t resp,
    output logic        resp_valid,
    input  logic        resp_ready,

    output wb_req_t     wb_out,
    input  wb_resp_t    wb_in
);

    fetch_req_t                q_req;
    logic                      q_req_valid;
    logic                      q_req_ready;
    fetch_resp_t               c_resp;
    logic                      c_resp_valid;
    logic                      c_resp_ready;
    logic                      fill_start;
    logic [`ICACHE_ADDR_W-1:0] fill_addr;
    logic                      fill_done;
    logic [`ICACHE_DATA_W-1:0] fill_data;

    // cpu requests into the controller
    fetch_queue #(
        .payload_t (fetch_req_t),
        .depth     (`ICACHE_QUEUE_DEPTH)
    ) req_queue (
        .clk       (clk),
        .rst       (rst),
        .in_data   (req),
        .in_valid  (req_valid),
        .in_ready  (req_ready),
        .out_data  (q_req),
        .out_valid (q_req_valid),
        .out_ready (q_req_ready)
    );

    icache_ctrl ctrl (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .req        (q_req),
        .req_valid  (q_req_valid),
        .req_ready  (q_req_ready),
        .resp       (c_resp),
        .resp_valid (c_resp_valid),
        .resp_ready (c_resp_ready),
        .fill_start (fill_start),
        .fill_addr  (fill_addr),
        .fill_done  (fill_done),
        .fill_data  (fill_data)
    );

    wb_line_fill line_fill (
        .clk        (clk),
        .rst        (rst),
        .fill_start (fill_start),
        .fill_addr  (fill_addr),
        .fill_done  (fill_done),
        .fill_data  (fill_data),
        .wb_out     (wb_out),
        .wb_in      (wb_in)
    );

    // responses back to the cpu in request order
    fetch_queue #(
        .payload_t (fetch_resp_t),
        .depth     (`ICACHE_QUEUE_DEPTH)
    ) resp_queue (
        .clk       (clk),
        .rst       (rst),
        .in_data   (c_resp),
        .in_valid  (c_resp_valid),
        .in_ready  (c_resp_ready),
        .out_data  (resp),
        .out_valid (resp_valid),
        .out_ready (resp_ready)
    );

endmodule

// ==== test/wb_mem_model.sv ====
`include "icache_cfg.svh"

module wb_mem_model
    import icache_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic [1:0] wait_cfg,
    input  wb_req_t    wb_req,
    output wb_resp_t   wb_resp
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [`ICACHE_DATA_W-1:0] words [logic [`ICACHE_ADDR_W-1:0]];
    logic                      in_cycle;
    logic [1:0]                wait_left;

    task automatic load_word(input logic [`ICACHE_ADDR_W-1:0] adr,
                             input logic [`ICACHE_DATA_W-1:0] dat);
        words[adr] = dat;
    endtask

    // words never loaded follow a pattern of the whole address
    function automatic logic [`ICACHE_DATA_W-1:0] read_word(input logic [`ICACHE_ADDR_W-1:0] adr);
        if (words.exists(adr))
            return words[adr];
        return {~adr, adr ^ 16'h5a3c};
    endfunction

    always @(posedge clk)
    begin : slave
        logic [1:0] waits;
        if (rst)
        begin
            wb_resp.ack <= 1'b0;
            wb_resp.dat <= '0;
            in_cycle    <= 1'b0;
            wait_left   <= '0;
        end
        else
        begin
            wb_resp.ack <= 1'b0;
            if (wb_req.cyc && wb_req.stb && !wb_resp.ack)
            begin
                // wait count taken when the cycle opens
                waits = in_cycle ? wait_left : wait_cfg;
                if (waits == 2'd0)
                begin
                    wb_resp.ack <= 1'b1;
                    wb_resp.dat <= read_word(wb_req.adr);
                    in_cycle    <= 1'b0;
                end
                else
                begin
                    in_cycle  <= 1'b1;
                    wait_left <= waits - 1'b1;
                end
            end
        end
    end

endmodule

// ==== test/icache_assertions.sv ====
module icache_assertions
    import icache_pkg::*;
(
    input logic        clk,
    input logic        rst,
    input fetch_req_t  q_req,
    input logic        q_req_valid,
    input logic        q_req_ready,
    input fetch_resp_t resp,
    input logic        resp_valid,
    input logic        resp_ready,
    input wb_req_t     wb_out,
    input wb_resp_t    wb_in
);

    timeunit 1ns;
    timeprecision 1ps;

    int failures;

    // open bus cycle stays put until ack
    assert property (@(posedge clk) disable iff (rst)
        wb_out.cyc && !wb_in.ack |=> wb_out.cyc && wb_out.stb && $stable(wb_out.adr))
    else
    begin
        $error("wishbone cycle dropped or address changed before ack");
        failures++;
    end

    assert property (@(posedge clk) disable iff (rst)
        wb_out.cyc && wb_in.ack |=> !wb_out.cyc)
    else
    begin
        $error("wishbone cycle not closed after ack");
        failures++;
    end

    assert property (@(posedge clk) disable iff (rst)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp))
    else
    begin
        $error("response dropped or changed while stalled");
        failures++;
    end

    // request queue output held while the controller is busy
    assert property (@(posedge clk) disable iff (rst)
        q_req_valid && !q_req_ready |=> q_req_valid && $stable(q_req))
    else
    begin
        $error("queued request dropped or changed while stalled");
        failures++;
    end

endmodule

bind icache_top icache_assertions checks (.*);

// ==== test/icache_tb.sv ====
`include "icache_cfg.svh"

module icache_tb
    import icache_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int num_lines = 1 << `ICACHE_INDEX_W;

    logic        clk;
    logic        rst;
    logic        flush;
    fetch_req_t  req;
    logic        req_valid;
    logic        req_ready;
    fetch_resp_t resp;
    logic        resp_valid;
    logic        resp_ready;
    wb_req_t     wb_out;
    wb_resp_t    wb_in;
    logic [1:0]  wait_cfg;

    // set by B and W lines, 4 or more means random wait states
    logic        backpressure;
    logic [3:0]  wait_mode;

    fetch_resp_t expected_q [$];
    int          resp_errors;
    int          fill_errors;
    int          other_errors;
    int          fill_count;
    int          predicted_fills;
    int          limit_cycles;

    // line state predicted from the direct mapping
    logic                     model_valid [num_lines];
    logic [`ICACHE_TAG_W-1:0] model_tag [num_lines];

    icache_top UUT (.*);

    wb_mem_model mem (.clk, .rst, .wait_cfg, .wb_req(wb_out), .wb_resp(wb_in));

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_resp(input fetch_resp_t expected, input fetch_resp_t actual);
        if (actual.addr !== expected.addr)
        begin
            resp_errors++;
            $display("Error resp.addr expected %h got %h", expected.addr, actual.addr);
        end
        if (actual.data !== expected.data)
        begin
            resp_errors++;
            $display("Error resp.data expected %h got %h", expected.data, actual.data);
        end
    endtask

    task automatic check_fills(input int expected, input int actual);
        if (actual != expected)
        begin
            fill_errors++;
            $display("Error wb read count expected %h got %h", expected, actual);
        end
    endtask

    task automatic send_request(input logic [`ICACHE_ADDR_W-1:0] addr,
                                input logic [`ICACHE_DATA_W-1:0] data);
        logic [`ICACHE_INDEX_W-1:0] index;
        logic [`ICACHE_TAG_W-1:0]   tag;
        index = addr[`ICACHE_INDEX_W-1:0];
        tag   = addr[`ICACHE_ADDR_W-1:`ICACHE_INDEX_W];
        if (!(model_valid[index] && model_tag[index] == tag))
            predicted_fills++;
        model_valid[index] = 1'b1;
        model_tag[index]   = tag;
        expected_q.push_back('{addr: addr, data: data});
        req.addr  = addr;
        req_valid = 1'b1;
        do
            @(posedge clk);
        while (!req_ready);
        #10;
        req_valid = 1'b0;
    endtask

    task automatic wait_for_responses();
        while (expected_q.size() != 0)
        begin
            @(posedge clk);
            #10;
        end
    endtask

    // cpu side of the response queue, plus wishbone read counting
    initial
    begin
        void'($urandom(32'hb857b02d));
        resp_ready = 1'b0;
        wait_cfg   = 2'd0;
        forever
        begin
            @(posedge clk);
            if (!rst && wb_out.cyc && wb_in.ack)
                fill_count++;
            if (!rst && resp_valid && resp_ready)
            begin
                if (expected_q.size() == 0)
                begin
                    other_errors++;
                    $display("response for %h arrived with no request outstanding", resp.addr);
                end
                else
                    check_resp(expected_q.pop_front(), resp);
            end
            #10;
            resp_ready = backpressure ? 1'($urandom_range(1, 0)) : 1'b1;
            wait_cfg   = (wait_mode > 3) ? 2'($urandom_range(3, 0)) : wait_mode[1:0];
        end
    end

    initial
    begin
        wait (limit_cycles != 0);
        repeat (limit_cycles) @(posedge clk);
        $display("run timed out after %0d clock cycles", limit_cycles);
        $display("Test FAILED");
        $finish;
    end

    initial
    begin
        string       test_lines [$];
        string       line;
        string       kind;
        logic [31:0] a;
        logic [31:0] b;
        int          fd;
        int          reads;
        rst          = 1'b1;
        flush        = 1'b0;
        req          = '0;
        req_valid    = 1'b0;
        backpressure = 1'b0;
        wait_mode    = '0;
        model_valid  = '{default: 1'b0};
        reads        = 0;
        fd = $fopen("test/icache_tests.txt", "r");
        if (fd == 0)
        begin
            $display("could not open test/icache_tests.txt");
            $display("Test FAILED");
            $finish;
        end
        else
        begin
            while ($fgets(line, fd) != 0)
            begin
                if (line.len() > 1 && line.getc(0) != "#")
                begin
                    test_lines.push_back(line);
                    if (line.getc(0) == "R")
                        reads++;
                end
            end
            $fclose(fd);
            limit_cycles = reads * 40 + 100;
            repeat (4) @(posedge clk);
            #10;
            rst = 1'b0;
            foreach (test_lines[i])
            begin
                a = '0;
                b = '0;
                void'($sscanf(test_lines[i], "%s %h %h", kind, a, b));
                case (kind)
                    "M": mem.load_word(a[`ICACHE_ADDR_W-1:0], b);
                    "R": send_request(a[`ICACHE_ADDR_W-1:0], b);
                    "B": backpressure = a[0];
                    "W": wait_mode = a[3:0];
                    "F":
                    begin
                        // drain first so the read count is settled
                        wait_for_responses();
                        check_fills(predicted_fills, fill_count);
                        flush = 1'b1;
                        @(posedge clk);
                        #10;
                        flush       = 1'b0;
                        model_valid = '{default: 1'b0};
                    end
                    default:
                    begin
                        other_errors++;
                        $display("unknown command in tests file: %s", test_lines[i]);
                    end
                endcase
            end
            wait_for_responses();
            check_fills(predicted_fills, fill_count);
            $display("errors: %0d response, %0d fill count, %0d assertion, %0d other",
                     resp_errors, fill_errors, UUT.checks.failures, other_errors);
            if (resp_errors + fill_errors + UUT.checks.failures + other_errors == 0)
                $display("Test OK");
            else
                $display("Test FAILED");
            $finish;
        end
    end

endmodule

// ==== sources.f ====
+incdir+source
source/icache_pkg.sv
source/fetch_queue.sv
source/wb_line_fill.sv
source/icache_ctrl.sv
source/icache_top.sv
test/wb_mem_model.sv
test/icache_assertions.sv
test/icache_tb.sv

// ==== test/icache_tests.txt ====
# M addr word: preload memory    R addr word: read addr, expect word
# F: flush    B n: random resp_ready stalls off/on    W n: wait states, 4 for random
M 0010 a0000010
M 0011 a1000011
M 0120 b2000120
M 0235 c3000235
M 1235 d4001235
W 0
R 0010 a0000010
R 0010 a0000010
R 0011 a1000011
R 0120 b2000120
R 0010 a0000010
R 0120 b2000120
R 0011 a1000011
F
R 0011 a1000011
R 0120 b2000120
R 0011 a1000011
W 3
R 0235 c3000235
R 1235 d4001235
R 0235 c3000235
R 0007 fff85a3b
B 1
W 4
R 0010 a0000010
R 0011 a1000011
R 0235 c3000235
R 1235 d4001235
R 0007 fff85a3b
R 0120 b2000120
R 0011 a1000011
R 0007 fff85a3b
B 0
R 0010 a0000010
